// File: verilog/cache_cfg.svh
// Data cache configuration
// Fixed geometry and memory-side credit count shared by packages and RTL
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Byte address and CPU data word widths
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// Fully associative, four lines of 16 bytes
`define CACHE_LINE_BYTES 16
`define CACHE_LINES 4

// Requests the memory side accepts before a credit has to come back
`define CACHE_MEM_CREDITS 2

`endif

// File: verilog/cache_cpu_pkg.sv
// CPU-side access types for the data cache
// Address, data word, opcode and access size
`include "cache_cfg.svh"

package cache_cpu_pkg;

  // Byte address and data word as the CPU sees them
  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_WORD_W-1:0] word_t;

  typedef enum logic {
    CPU_READ  = 1'b0,
    CPU_WRITE = 1'b1
  } cpu_op_e;

  // Only byte and full word accesses exist
  typedef enum logic {
    SIZE_BYTE = 1'b0,
    SIZE_WORD = 1'b1
  } access_size_e;

endpackage

// File: verilog/cache_line_pkg.sv
// Line-level types for the data cache
// Line, tag and way types, memory request opcodes and controller states
`include "cache_cfg.svh"

package cache_line_pkg;

  // Address split: tag above the line offset, word and byte select below it
  localparam int OFFSET_W       = $clog2(`CACHE_LINE_BYTES);
  localparam int BYTE_SEL_W     = $clog2(`CACHE_WORD_W / 8);
  localparam int WORDS_PER_LINE = `CACHE_LINE_BYTES * 8 / `CACHE_WORD_W;
  localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

  // Little-endian line, byte k of the line sits at bits [8k +: 8]
  typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;
  typedef logic [`CACHE_ADDR_W-OFFSET_W-1:0] tag_t;
  typedef logic [$clog2(`CACHE_LINES)-1:0] way_t;

  typedef enum logic {
    MEM_FETCH     = 1'b0,
    MEM_WRITEBACK = 1'b1
  } mem_op_e;

  // Access and miss sequence of the controller
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_EVICT,
    ST_FILL_REQ,
    ST_FILL_WAIT,
    ST_COMPLETE
  } cache_state_e;

endpackage

// File: verilog/cache_ifs.sv
// Controller to datapath interfaces of the data cache
// lookup_if goes to the tag store, store_if to the data array
`timescale 1ns/1ps

interface lookup_if;
  import cache_line_pkg::*;

  // Driven by the controller
  tag_t tag;
  logic install;
  way_t install_way;
  tag_t install_tag;
  logic set_dirty;
  way_t dirty_way;

  // Driven by the tag store
  logic hit;
  way_t hit_way;
  logic victim_valid;
  logic victim_dirty;
  tag_t victim_tag;

  // install_way also names the way whose victim status is reported
  modport ctrl (
    output tag, install, install_way, install_tag, set_dirty, dirty_way,
    input  hit, hit_way, victim_valid, victim_dirty, victim_tag
  );

  modport tags (
    input  tag, install, install_way, install_tag, set_dirty, dirty_way,
    output hit, hit_way, victim_valid, victim_dirty, victim_tag
  );
endinterface

interface store_if;
  import cache_cpu_pkg::*;
  import cache_line_pkg::*;

  way_t                  way;
  logic [WORD_SEL_W-1:0] word_sel;
  logic [BYTE_SEL_W-1:0] byte_sel;
  logic                  write_word;
  logic                  write_byte;
  word_t                 wdata;
  logic                  fill;
  line_t                 fill_line;

  word_t                 rdata;
  line_t                 victim_line;

  modport ctrl (
    output way, word_sel, byte_sel, write_word, write_byte, wdata, fill, fill_line,
    input  rdata, victim_line
  );

  modport data (
    input  way, word_sel, byte_sel, write_word, write_byte, wdata, fill, fill_line,
    output rdata, victim_line
  );
endinterface

// File: verilog/tag_match.sv
// Tag store of the data cache
// Holds tag, valid and dirty per way, compares all tags in parallel
`timescale 1ns/1ps
`include "cache_cfg.svh"

module tag_match (
  input logic    clk,
  input logic    reset,
  lookup_if.tags lookup
);
  import cache_line_pkg::*;

  tag_t                    tag_q [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid_q;
  logic [`CACHE_LINES-1:0] dirty_q;
  logic [`CACHE_LINES-1:0] hit_vec;

  // One comparator per way
  always_comb
  begin
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      hit_vec[i] = valid_q[i] && (tag_q[i] == lookup.tag);
    end
  end

  assign lookup.hit = |hit_vec;

  always_comb
  begin
    lookup.hit_way = '0;
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      if (hit_vec[i])
      begin
        lookup.hit_way = way_t'(i);
      end
    end
  end

  // Status of the way the controller is about to replace
  assign lookup.victim_valid = valid_q[lookup.install_way];
  assign lookup.victim_dirty = dirty_q[lookup.install_way];
  assign lookup.victim_tag   = tag_q[lookup.install_way];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      // A freshly fetched line is clean
      if (lookup.install)
      begin
        valid_q[lookup.install_way] <= 1'b1;
        dirty_q[lookup.install_way] <= 1'b0;
      end
      if (lookup.set_dirty)
      begin
        dirty_q[lookup.dirty_way] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (lookup.install)
    begin
      tag_q[lookup.install_way] <= lookup.install_tag;
    end
  end

  // Lines are only installed after a miss, so a tag never sits in two ways
  a_single_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec))
    else $error("tag_match: more than one way hit");

endmodule

// File: verilog/lru_tracker.sv
// LRU order of the data cache lines
// One age counter per way, the way at age zero is the next victim
`timescale 1ns/1ps
`include "cache_cfg.svh"

module lru_tracker (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 touch,
  input  cache_line_pkg::way_t touch_way,
  output cache_line_pkg::way_t lru_way
);
  import cache_line_pkg::*;

  // Age LINES-1 is the most recent way, the counters stay a permutation
  way_t age_q [`CACHE_LINES];

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `CACHE_LINES; i++)
      begin
        age_q[i] <= way_t'(i);
      end
    end
    else if (touch)
    begin
      // Ways more recent than the touched one move down a step
      for (int i = 0; i < `CACHE_LINES; i++)
      begin
        if (way_t'(i) == touch_way)
        begin
          age_q[i] <= way_t'(`CACHE_LINES - 1);
        end
        else if (age_q[i] > age_q[touch_way])
        begin
          age_q[i] <= age_q[i] - 1'b1;
        end
      end
    end
  end

  always_comb
  begin
    lru_way = '0;
    for (int i = 0; i < `CACHE_LINES; i++)
    begin
      if (age_q[i] == '0)
      begin
        lru_way = way_t'(i);
      end
    end
  end

endmodule

// File: verilog/line_store.sv
// Data array of the data cache
// Word and byte access, whole-line fill and whole-line victim readout
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_store (
  input logic   clk,
  store_if.data store
);
  import cache_cpu_pkg::*;
  import cache_line_pkg::*;

  // Word w of a line holds line bytes 4w to 4w+3
  word_t data_q [`CACHE_LINES][WORDS_PER_LINE];

  always_ff @(posedge clk)
  begin
    if (store.fill)
    begin
      for (int w = 0; w < WORDS_PER_LINE; w++)
      begin
        data_q[store.way][w] <= store.fill_line[w*`CACHE_WORD_W +: `CACHE_WORD_W];
      end
    end
    else if (store.write_word)
    begin
      data_q[store.way][store.word_sel] <= store.wdata;
    end
    else if (store.write_byte)
    begin
      // Only the addressed lane changes
      data_q[store.way][store.word_sel][store.byte_sel*8 +: 8] <= store.wdata[7:0];
    end
  end

  assign store.rdata = data_q[store.way][store.word_sel];

  // Whole line of the selected way, ready for a writeback
  always_comb
  begin
    for (int w = 0; w < WORDS_PER_LINE; w++)
    begin
      store.victim_line[w*`CACHE_WORD_W +: `CACHE_WORD_W] = data_q[store.way][w];
    end
  end

endmodule

// File: verilog/cache_ctrl.sv
// Data cache controller
// Access and miss FSM, memory credit counter and line request issue
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cpu_req,
  input  cache_cpu_pkg::cpu_op_e      cpu_op,
  input  cache_cpu_pkg::access_size_e cpu_size,
  input  cache_cpu_pkg::addr_t        cpu_addr,
  input  cache_cpu_pkg::word_t        cpu_wdata,
  output logic                        cpu_ready,
  output logic                        cpu_resp_valid,
  output cache_cpu_pkg::word_t        cpu_rdata,
  lookup_if.ctrl                      lookup,
  store_if.ctrl                       store,
  input  cache_line_pkg::way_t        lru_way,
  output logic                        touch,
  output cache_line_pkg::way_t        touch_way,
  output logic                        mem_req_valid,
  output cache_line_pkg::mem_op_e     mem_req_op,
  output cache_cpu_pkg::addr_t        mem_req_addr,
  output cache_line_pkg::line_t       mem_req_line,
  input  logic                        mem_credit,
  input  logic                        mem_resp_valid,
  input  cache_line_pkg::line_t       mem_resp_line
);
  import cache_cpu_pkg::*;
  import cache_line_pkg::*;

  localparam int CREDIT_W = $clog2(`CACHE_MEM_CREDITS + 1);

  cache_state_e          state_q;
  cpu_op_e               op_q;
  access_size_e          size_q;
  addr_t                 addr_q;
  word_t                 wdata_q;
  way_t                  way_q;
  logic [CREDIT_W-1:0]   credit_q;

  tag_t                  req_tag;
  logic [WORD_SEL_W-1:0] req_word;
  logic [BYTE_SEL_W-1:0] req_byte;
  logic                  is_write;
  logic                  fill_now;
  logic                  issue;

  assign req_tag  = addr_q[`CACHE_ADDR_W-1:OFFSET_W];
  assign req_word = addr_q[OFFSET_W-1:BYTE_SEL_W];
  assign req_byte = addr_q[BYTE_SEL_W-1:0];
  assign is_write = (op_q == CPU_WRITE);
  assign fill_now = (state_q == ST_FILL_WAIT) && mem_resp_valid;

  assign cpu_ready = (state_q == ST_IDLE);

  // Writeback and fetch both wait here until a credit is held
  assign issue = ((state_q == ST_EVICT) || (state_q == ST_FILL_REQ)) && (credit_q != '0);

  always_comb
  begin
    lookup.tag         = req_tag;
    lookup.install     = fill_now;
    // In lookup the LRU way is the candidate victim, later the chosen way
    lookup.install_way = (state_q == ST_LOOKUP) ? lru_way : way_q;
    lookup.install_tag = req_tag;
    lookup.set_dirty   = (state_q == ST_COMPLETE) && is_write;
    lookup.dirty_way   = way_q;

    store.way        = way_q;
    store.word_sel   = req_word;
    store.byte_sel   = req_byte;
    store.write_word = (state_q == ST_COMPLETE) && is_write && (size_q == SIZE_WORD);
    store.write_byte = (state_q == ST_COMPLETE) && is_write && (size_q == SIZE_BYTE);
    store.wdata      = wdata_q;
    store.fill       = fill_now;
    store.fill_line  = mem_resp_line;
  end

  assign touch     = (state_q == ST_COMPLETE);
  assign touch_way = way_q;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state_q        <= ST_IDLE;
      credit_q       <= CREDIT_W'(`CACHE_MEM_CREDITS);
      cpu_resp_valid <= 1'b0;
      mem_req_valid  <= 1'b0;
    end
    else
    begin
      cpu_resp_valid <= 1'b0;
      mem_req_valid  <= issue;
      credit_q       <= credit_q - CREDIT_W'(issue) + CREDIT_W'(mem_credit);
      case (state_q)
        ST_IDLE:
        begin
          if (cpu_req)
          begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP:
        begin
          if (lookup.hit)
          begin
            state_q <= ST_COMPLETE;
          end
          else if (lookup.victim_valid && lookup.victim_dirty)
          begin
            state_q <= ST_EVICT;
          end
          else
          begin
            state_q <= ST_FILL_REQ;
          end
        end
        ST_EVICT:
        begin
          if (issue)
          begin
            state_q <= ST_FILL_REQ;
          end
        end
        ST_FILL_REQ:
        begin
          if (issue)
          begin
            state_q <= ST_FILL_WAIT;
          end
        end
        ST_FILL_WAIT:
        begin
          if (mem_resp_valid)
          begin
            state_q <= ST_COMPLETE;
          end
        end
        ST_COMPLETE:
        begin
          state_q        <= ST_IDLE;
          cpu_resp_valid <= 1'b1;
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Request, way and memory request payload
  always_ff @(posedge clk)
  begin
    if (cpu_ready && cpu_req)
    begin
      op_q    <= cpu_op;
      size_q  <= cpu_size;
      addr_q  <= cpu_addr;
      wdata_q <= cpu_wdata;
    end
    if (state_q == ST_LOOKUP)
    begin
      way_q <= lookup.hit ? lookup.hit_way : lru_way;
    end
    if (issue)
    begin
      if (state_q == ST_EVICT)
      begin
        mem_req_op   <= MEM_WRITEBACK;
        mem_req_addr <= {lookup.victim_tag, {OFFSET_W{1'b0}}};
      end
      else
      begin
        mem_req_op   <= MEM_FETCH;
        mem_req_addr <= {req_tag, {OFFSET_W{1'b0}}};
      end
      mem_req_line <= store.victim_line;
    end
    // Byte reads come back zero-extended
    if ((state_q == ST_COMPLETE) && !is_write)
    begin
      if (size_q == SIZE_WORD)
      begin
        cpu_rdata <= store.rdata;
      end
      else
      begin
        cpu_rdata <= word_t'(store.rdata[req_byte*8 +: 8]);
      end
    end
  end

  // Memory must not return more credits than it has been sent requests
  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
    credit_q <= CREDIT_W'(`CACHE_MEM_CREDITS))
    else $error("cache_ctrl: credit count above %0d", `CACHE_MEM_CREDITS);

  // With no credit left a pending request stalls in its state and sends nothing
  a_req_has_credit: assert property (@(posedge clk) disable iff (reset)
    (credit_q == '0) && ((state_q == ST_EVICT) || (state_q == ST_FILL_REQ))
    |=> !mem_req_valid && (state_q == $past(state_q)))
    else $error("cache_ctrl: memory request sent without a credit");

endmodule

// File: verilog/cache_top.sv
// Data cache top level
// Controller, tag store, LRU tracker and data array behind plain ports
`timescale 1ns/1ps

module cache_top (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cpu_req,
  input  cache_cpu_pkg::cpu_op_e      cpu_op,
  input  cache_cpu_pkg::access_size_e cpu_size,
  input  cache_cpu_pkg::addr_t        cpu_addr,
  input  cache_cpu_pkg::word_t        cpu_wdata,
  output logic                        cpu_ready,
  output logic                        cpu_resp_valid,
  output cache_cpu_pkg::word_t        cpu_rdata,
  output logic                        mem_req_valid,
  output cache_line_pkg::mem_op_e     mem_req_op,
  output cache_cpu_pkg::addr_t        mem_req_addr,
  output cache_line_pkg::line_t       mem_req_line,
  input  logic                        mem_credit,
  input  logic                        mem_resp_valid,
  input  cache_line_pkg::line_t       mem_resp_line
);
  import cache_line_pkg::*;

  way_t lru_way;
  logic touch;
  way_t touch_way;

  lookup_if lookup_i ();
  store_if  store_i ();

  cache_ctrl cache_ctrl_i (
    .clk            (clk),
    .reset          (reset),
    .cpu_req        (cpu_req),
    .cpu_op         (cpu_op),
    .cpu_size       (cpu_size),
    .cpu_addr       (cpu_addr),
    .cpu_wdata      (cpu_wdata),
    .cpu_ready      (cpu_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .cpu_rdata      (cpu_rdata),
    .lookup         (lookup_i.ctrl),
    .store          (store_i.ctrl),
    .lru_way        (lru_way),
    .touch          (touch),
    .touch_way      (touch_way),
    .mem_req_valid  (mem_req_valid),
    .mem_req_op     (mem_req_op),
    .mem_req_addr   (mem_req_addr),
    .mem_req_line   (mem_req_line),
    .mem_credit     (mem_credit),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_line  (mem_resp_line)
  );

  tag_match tag_match_i (
    .clk    (clk),
    .reset  (reset),
    .lookup (lookup_i.tags)
  );

  lru_tracker lru_tracker_i (
    .clk       (clk),
    .reset     (reset),
    .touch     (touch),
    .touch_way (touch_way),
    .lru_way   (lru_way)
  );

  line_store line_store_i (
    .clk   (clk),
    .store (store_i.data)
  );

endmodule

// File: verification/line_memory_model.sv
// Backing memory for the data cache testbench
// Queues line requests, serves them after a random delay and returns credits
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_memory_model (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    slow,
  input  logic                    mem_req_valid,
  input  cache_line_pkg::mem_op_e mem_req_op,
  input  cache_cpu_pkg::addr_t    mem_req_addr,
  input  cache_line_pkg::line_t   mem_req_line,
  output logic                    mem_credit,
  output logic                    mem_resp_valid,
  output cache_line_pkg::line_t   mem_resp_line
);
  import cache_cpu_pkg::*;
  import cache_line_pkg::*;

  // Extra cycles per request while slow is high
  localparam int SLOW_EXTRA = 16;

  // Only the low 4 KB are backed
  logic [7:0]  bytes_q [0:4095];
  logic        op_q [$];
  addr_t       addr_q [$];
  line_t       line_q [$];
  logic [31:0] lcg_state;
  int          wait_cnt;
  logic        op_v;
  addr_t       base_v;
  line_t       line_v;

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  // Delay of 1 to 8 cycles from a linear congruential generator
  function automatic int next_delay();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return 1 + int'(lcg_state[18:16]);
  endfunction

  initial
  begin
    lcg_state      = 32'h0a08d478;
    wait_cnt       = 0;
    mem_credit     = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_line  = '0;
    for (int i = 0; i < 4096; i++)
    begin
      bytes_q[i] = fill_byte(i);
    end
  end

  // Requests are served in arrival order, one at a time
  always @(negedge clk)
  begin
    mem_credit     <= 1'b0;
    mem_resp_valid <= 1'b0;
    if (reset)
    begin
      op_q.delete();
      addr_q.delete();
      line_q.delete();
      wait_cnt = 0;
    end
    else
    begin
      if (mem_req_valid)
      begin
        op_q.push_back(mem_req_op);
        addr_q.push_back(mem_req_addr);
        line_q.push_back(mem_req_line);
      end
      if (op_q.size() > 0)
      begin
        if (wait_cnt == 0)
        begin
          wait_cnt = next_delay() + (slow ? SLOW_EXTRA : 0);
        end
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0)
        begin
          op_v   = op_q.pop_front();
          base_v = addr_q.pop_front();
          line_v = line_q.pop_front();
          mem_credit <= 1'b1;
          for (int b = 0; b < `CACHE_LINE_BYTES; b++)
          begin
            if (op_v == MEM_WRITEBACK)
            begin
              bytes_q[int'(base_v[11:0]) + b] = line_v[8*b +: 8];
            end
            else
            begin
              line_v[8*b +: 8] = bytes_q[int'(base_v[11:0]) + b];
            end
          end
          // Writebacks get no response
          if (op_v != MEM_WRITEBACK)
          begin
            mem_resp_valid <= 1'b1;
            mem_resp_line  <= line_v;
          end
        end
      end
    end
  end

endmodule

// File: verification/cache_tb.sv
// Data cache testbench
// Runs the access cases from a file against a reference memory image
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;
  import cache_cpu_pkg::*;
  import cache_line_pkg::*;

  localparam int MAX_CASES   = 64;
  localparam int CASE_CYCLES = 40;

  logic         clk;
  logic         reset;
  logic         cpu_req;
  cpu_op_e      cpu_op;
  access_size_e cpu_size;
  addr_t        cpu_addr;
  word_t        cpu_wdata;
  logic         cpu_ready;
  logic         cpu_resp_valid;
  word_t        cpu_rdata;
  logic         mem_req_valid;
  mem_op_e      mem_req_op;
  addr_t        mem_req_addr;
  line_t        mem_req_line;
  logic         mem_credit;
  logic         mem_resp_valid;
  line_t        mem_resp_line;
  logic         slow;

  logic [31:0]  case_words [0:5*MAX_CASES-1];
  logic [7:0]   ref_mem [0:4095];
  // Resident lines, least recently used first
  addr_t        lru_lines [$];
  logic         lru_dirty [$];
  addr_t        cur_line;
  addr_t        exp_wb_addr;
  int           num_cases = 0;
  int           err_cnt = 0;
  int           pass_cnt = 0;
  int           fail_cnt = 0;
  int           fetch_total = 0;
  int           wb_total = 0;
  int           outstanding = 0;

  cache_top cache_top_i (
    .clk            (clk),
    .reset          (reset),
    .cpu_req        (cpu_req),
    .cpu_op         (cpu_op),
    .cpu_size       (cpu_size),
    .cpu_addr       (cpu_addr),
    .cpu_wdata      (cpu_wdata),
    .cpu_ready      (cpu_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .cpu_rdata      (cpu_rdata),
    .mem_req_valid  (mem_req_valid),
    .mem_req_op     (mem_req_op),
    .mem_req_addr   (mem_req_addr),
    .mem_req_line   (mem_req_line),
    .mem_credit     (mem_credit),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_line  (mem_resp_line)
  );

  line_memory_model line_memory_model_i (
    .clk            (clk),
    .reset          (reset),
    .slow           (slow),
    .mem_req_valid  (mem_req_valid),
    .mem_req_op     (mem_req_op),
    .mem_req_addr   (mem_req_addr),
    .mem_req_line   (mem_req_line),
    .mem_credit     (mem_credit),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_line  (mem_resp_line)
  );

  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
  endfunction

  function automatic word_t ref_read(input addr_t addr, input logic byte_access);
    int base;
    base = int'(addr[11:0]);
    if (byte_access)
    begin
      return {24'h0, ref_mem[base]};
    end
    base = base & ~3;
    return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
  endfunction

  function automatic line_t ref_line(input addr_t addr);
    line_t line;
    for (int b = 0; b < `CACHE_LINE_BYTES; b++)
    begin
      line[8*b +: 8] = ref_mem[int'(addr[11:0]) + b];
    end
    return line;
  endfunction

  task automatic ref_write(input addr_t addr, input logic byte_access, input word_t wdata);
    int base;
    base = int'(addr[11:0]);
    if (byte_access)
    begin
      ref_mem[base] = wdata[7:0];
    end
    else
    begin
      base = base & ~3;
      for (int b = 0; b < 4; b++)
      begin
        ref_mem[base+b] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic value_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
    err_cnt++;
  endtask

  // True LRU over four lines, gives the memory traffic an access must cause
  task automatic predict_traffic(input addr_t line, input logic is_write,
                                 output int fetches, output int writebacks);
    int   hit_idx;
    logic dirty;
    hit_idx    = -1;
    dirty      = is_write;
    fetches    = 0;
    writebacks = 0;
    for (int i = 0; i < lru_lines.size(); i++)
    begin
      if (lru_lines[i] == line)
      begin
        hit_idx = i;
      end
    end
    if (hit_idx >= 0)
    begin
      dirty = dirty | lru_dirty[hit_idx];
      lru_lines.delete(hit_idx);
      lru_dirty.delete(hit_idx);
    end
    else
    begin
      fetches = 1;
      if (lru_lines.size() == `CACHE_LINES)
      begin
        exp_wb_addr = lru_lines.pop_front();
        if (lru_dirty.pop_front())
        begin
          writebacks = 1;
        end
      end
    end
    lru_lines.push_back(line);
    lru_dirty.push_back(dirty);
  endtask

  task automatic run_case(input int n);
    logic [31:0] op_word;
    logic        is_write;
    logic        byte_access;
    addr_t       addr;
    word_t       wdata;
    word_t       exp_data;
    int          exp_fetch;
    int          exp_wb;
    int          fetch_start;
    int          wb_start;
    int          errs_start;
    int          cycles;
    op_word     = case_words[5*n];
    is_write    = op_word[0];
    byte_access = (case_words[5*n+1][0] == 1'b0);
    addr        = case_words[5*n+2];
    wdata       = case_words[5*n+3];
    exp_data    = case_words[5*n+4];
    errs_start  = err_cnt;
    while (!cpu_ready)
    begin
      @(negedge clk);
    end
    cur_line = addr & ~addr_t'(`CACHE_LINE_BYTES - 1);
    predict_traffic(cur_line, is_write, exp_fetch, exp_wb);
    slow        = op_word[4];
    fetch_start = fetch_total;
    wb_start    = wb_total;
    cpu_req     = 1'b1;
    cpu_op      = cpu_op_e'(is_write);
    cpu_size    = byte_access ? SIZE_BYTE : SIZE_WORD;
    cpu_addr    = addr;
    cpu_wdata   = wdata;
    @(negedge clk);
    cpu_req = 1'b0;
    cycles  = 1;
    while (!cpu_resp_valid)
    begin
      @(negedge clk);
      cycles++;
    end
    // A hit answers two cycles after the accepting edge
    if (exp_fetch == 0 && cycles != 3)
    begin
      value_mismatch("hit latency in cycles", cycles, 3);
    end
    if (fetch_total - fetch_start != exp_fetch)
    begin
      value_mismatch("fetch count", fetch_total - fetch_start, exp_fetch);
    end
    if (wb_total - wb_start != exp_wb)
    begin
      value_mismatch("writeback count", wb_total - wb_start, exp_wb);
    end
    if (is_write)
    begin
      ref_write(addr, byte_access, wdata);
    end
    else
    begin
      if (exp_data !== ref_read(addr, byte_access))
      begin
        $display("Case %0d in the case file expects %h but the reference image holds %h",
                 n, exp_data, ref_read(addr, byte_access));
        err_cnt++;
      end
      if (cpu_rdata !== exp_data)
      begin
        value_mismatch("cpu_rdata", cpu_rdata, exp_data);
      end
    end
    if (err_cnt == errs_start)
    begin
      pass_cnt++;
    end
    else
    begin
      fail_cnt++;
    end
    $display("case %0d: %s %s at %h%s: %s", n, is_write ? "write" : "read",
             byte_access ? "byte" : "word", addr, slow ? " (slow memory)" : "",
             (err_cnt == errs_start) ? "ok" : "error");
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Credits come back on the rising edge, requests are counted on the falling one
  always @(posedge clk)
  begin
    if (!reset && mem_credit)
    begin
      outstanding--;
    end
  end

  always @(negedge clk)
  begin
    if (!reset)
    begin
      outstanding = outstanding + int'(mem_req_valid);
      if (outstanding > `CACHE_MEM_CREDITS || outstanding < 0)
      begin
        $display("Credit rule broken at %0t ns: %0d memory requests outstanding",
                 $time, outstanding);
        err_cnt++;
      end
      if (mem_req_valid && mem_req_op == MEM_FETCH)
      begin
        fetch_total++;
        if (mem_req_addr !== cur_line)
        begin
          value_mismatch("fetch address", mem_req_addr, cur_line);
        end
      end
      if (mem_req_valid && mem_req_op == MEM_WRITEBACK)
      begin
        wb_total++;
        if (mem_req_addr !== exp_wb_addr)
        begin
          value_mismatch("writeback address", mem_req_addr, exp_wb_addr);
        end
        if (mem_req_line !== ref_line(mem_req_addr))
        begin
          $display("[FAIL] %0t ns: writeback line is %h, expected %h",
                   $time, mem_req_line, ref_line(mem_req_addr));
          err_cnt++;
        end
      end
    end
  end

  // Watchdog sized by the number of cases
  initial
  begin
    #1;
    repeat (num_cases * CASE_CYCLES + 20) @(posedge clk);
    $display("Timeout: the cases did not finish within %0d cycles",
             num_cases * CASE_CYCLES + 20);
    $display("TB FAILED");
    $finish;
  end

  initial
  begin
    reset     = 1'b1;
    slow      = 1'b0;
    cpu_req   = 1'b0;
    cpu_op    = CPU_READ;
    cpu_size  = SIZE_WORD;
    cpu_addr  = '0;
    cpu_wdata = '0;
    for (int i = 0; i < 4096; i++)
    begin
      ref_mem[i] = fill_byte(i);
    end
    for (int i = 0; i < 5*MAX_CASES; i++)
    begin
      case_words[i] = 32'hFFFF_FFFF;
    end
    $readmemh("verification/cache_cases.txt", case_words);
    while (num_cases < MAX_CASES && case_words[5*num_cases] !== 32'hFFFF_FFFF)
    begin
      num_cases++;
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (cpu_ready !== 1'b1 || mem_req_valid !== 1'b0)
    begin
      $display("DUT is not idle after reset: cpu_ready %b, mem_req_valid %b",
               cpu_ready, mem_req_valid);
      err_cnt++;
    end
    if (num_cases == 0)
    begin
      $display("No test cases were read from the case file");
      err_cnt++;
    end
    for (int n = 0; n < num_cases; n++)
    begin
      run_case(n);
    end
    $display("Summary: %0d cases passed, %0d cases failed, %0d errors",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: cache_sys.f
+incdir+verilog
verilog/cache_cpu_pkg.sv
verilog/cache_line_pkg.sv
verilog/cache_ifs.sv
verilog/tag_match.sv
verilog/lru_tracker.sv
verilog/line_store.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
verification/line_memory_model.sv
verification/cache_tb.sv

// File: verification/cache_cases.txt
// Data cache cases, all fields hex: op size address wdata expected
// op 00 read, 01 write, 10 and 11 the same under long memory latency; size 0 byte, 1 word
// First reads fetch, writes then reads hit the resident line
00 1 00000100 00000000 A7A6A5A4
00 1 00000104 00000000 A3A2A1A0
01 1 00000108 12345678 00000000
00 1 00000108 00000000 12345678
00 1 0000010C 00000000 ABAAA9A8
// Byte lanes
00 1 00000200 00000000 A4A5A6A7
01 0 00000201 0000005A 00000000
00 1 00000200 00000000 A4A55AA7
00 0 00000201 00000000 0000005A
00 0 00000203 00000000 000000A4
01 0 00000202 123456F0 00000000
00 1 00000200 00000000 A4F05AA7
00 0 00000200 00000000 000000A7
// Five lines, dirty victims written back and read again
00 1 00000300 00000000 A5A4A7A6
01 1 00000404 CAFEF00D 00000000
00 1 00000500 00000000 A3A2A1A0
00 1 00000404 00000000 CAFEF00D
00 1 00000108 00000000 12345678
00 1 00000200 00000000 A4F05AA7
00 0 00000202 00000000 000000F0
00 1 00000600 00000000 A0A1A2A3
00 1 00000700 00000000 A1A0A3A2
00 1 00000404 00000000 CAFEF00D
// Long memory latency
11 1 00000800 0BADBEEF 00000000
11 1 00000900 600DF00D 00000000
10 1 00000A00 00000000 ACADAEAF
10 1 00000B04 00000000 A9A8ABAA
10 1 00000C00 00000000 AAABA8A9
10 1 00000D08 00000000 A3A2A1A0
// Lines written back under long latency
00 1 00000800 00000000 0BADBEEF
00 1 00000900 00000000 600DF00D
00 0 00000903 00000000 00000060
00 1 0000010C 00000000 ABAAA9A8
01 0 0000010F 00000011 00000000
00 1 0000010C 00000000 11AAA9A8
